//--- rv_core_pkg.sv
// RV64 integer core shared types
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 64;             // data width
    localparam int NUM_REGS   = 32;             // architectural registers
    localparam int REG_ADDR_W = 5;              // register index width

    localparam logic [31:0] EBREAK_INST = 32'h0010_0073;  // the one and only ebreak

    // major opcodes that pick the operand form
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;   // addi, slti, slli ...
    localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;   // addiw, slliw ...
    localparam logic [6:0] OPC_OP32     = 7'b0111011;   // addw, subw ...
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,                                // pass operand b
        ALU_AUIPC                               // pc + operand b
    } alu_op_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } inst_in_t;                                // input stream item

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  word;            // 32-bit op, sign-extend result
        logic                  use_imm;         // operand b is imm
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  writes_rd;       // never set for x0
        logic                  illegal;
        logic                  ebreak;
        logic [XLEN-1:0]       pc;
    } decoded_t;

    typedef struct packed {
        decoded_t        dec;
        logic [XLEN-1:0] op_a;                  // forwarded rs1
        logic [XLEN-1:0] op_b;                  // forwarded rs2 or imm
    } exec_t;                                   // stage 1 payload

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  writes_rd;
        logic                  illegal;
        logic                  ebreak;
    } wb_t;                                     // stage 2 payload and output record

endpackage

`default_nettype wire

//--- rv_idu.sv
// RV64 integer instruction decoder
`default_nettype none

module rv_idu (
    input  logic [31:0]                  inst,
    input  logic [rv_core_pkg::XLEN-1:0] pc,
    output rv_core_pkg::decoded_t        dec
);
    import rv_core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_sh;
    logic            is_shift;                  // funct3 of a shift-immediate
    logic            is_ebreak;
    logic            legal;                     // matched a supported encoding
    alu_op_t         op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i  = {{(XLEN-12){inst[31]}}, inst[31:20]};        // sign-extended I
    assign imm_u  = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0}; // upper 20 bits of U
    assign imm_sh = {{(XLEN-6){1'b0}}, inst[25:20]};             // 6-bit shamt
    assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign is_ebreak = (inst == EBREAK_INST);                    // exact match only

    // keyed on funct7, funct3 and opcode
    always_comb begin
        legal = 1'b1;
        op    = ALU_ADD;
        casez ({funct7, funct3, opcode})
            17'b0000000_000_0110011,                        // add
            17'b???????_000_0010011,                        // addi
            17'b0000000_000_0111011,                        // addw
            17'b???????_000_0011011: op = ALU_ADD;          // addiw
            17'b0100000_000_0110011,                        // sub
            17'b0100000_000_0111011: op = ALU_SUB;          // subw
            17'b0000000_001_0110011,                        // sll
            17'b000000?_001_0010011,                        // slli with 6-bit shamt
            17'b0000000_001_0111011,                        // sllw
            17'b0000000_001_0011011: op = ALU_SLL;          // slliw needs bit 25 zero
            17'b0000000_010_0110011,                        // slt
            17'b???????_010_0010011: op = ALU_SLT;          // slti
            17'b0000000_011_0110011,                        // sltu
            17'b???????_011_0010011: op = ALU_SLTU;         // sltiu
            17'b0000000_100_0110011,                        // xor
            17'b???????_100_0010011: op = ALU_XOR;          // xori
            17'b0000000_101_0110011,                        // srl
            17'b000000?_101_0010011,                        // srli
            17'b0000000_101_0111011,                        // srlw
            17'b0000000_101_0011011: op = ALU_SRL;          // srliw
            17'b0100000_101_0110011,                        // sra
            17'b010000?_101_0010011,                        // srai
            17'b0100000_101_0111011,                        // sraw
            17'b0100000_101_0011011: op = ALU_SRA;          // sraiw
            17'b0000000_110_0110011,                        // or
            17'b???????_110_0010011: op = ALU_OR;           // ori
            17'b0000000_111_0110011,                        // and
            17'b???????_111_0010011: op = ALU_AND;          // andi
            17'b???????_???_0110111: op = ALU_LUI;          // lui
            17'b???????_???_0010111: op = ALU_AUIPC;        // auipc
            default:                 legal = 1'b0;          // ebreak lands here too
        endcase
    end

    // operand form follows the major opcode
    always_comb begin
        dec.alu_op  = op;
        dec.pc      = pc;
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.word    = (opcode == OPC_OP32) || (opcode == OPC_OP_IMM32);
        dec.use_imm = 1'b0;
        dec.imm     = imm_i;
        case (opcode)
            OPC_OP_IMM, OPC_OP_IMM32: begin
                dec.use_imm = 1'b1;
                dec.imm     = is_shift ? imm_sh : imm_i;     // shamt instead of I-imm
            end
            OPC_LUI, OPC_AUIPC: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
            end
            default: begin
                dec.use_imm = 1'b0;                         // register-register
            end
        endcase
        dec.ebreak    = is_ebreak;
        dec.illegal   = !legal && !is_ebreak;
        dec.writes_rd = legal && (inst[11:7] != '0);        // x0 writes dropped here
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
// Integer register file
`default_nettype none

module rv_regfile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    input  logic                              we,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [rv_core_pkg::XLEN-1:0]       wr_data
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];       // x0 has no storage

    // write port, retirement edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;                  // architectural state starts at zero
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;           // x0 writes ignored
        end
    end

    // async read ports
    always_comb begin
        rs1_data = '0;                          // x0 reads zero
        rs2_data = '0;
        if (rs1_addr != '0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

//--- rv_alu.sv
// RV64 integer ALU
`default_nettype none

module rv_alu (
    input  rv_core_pkg::alu_op_t         op,
    input  logic                         word,
    input  logic [rv_core_pkg::XLEN-1:0] a,
    input  logic [rv_core_pkg::XLEN-1:0] b,
    input  logic [rv_core_pkg::XLEN-1:0] pc,
    output logic [rv_core_pkg::XLEN-1:0] result
);
    import rv_core_pkg::*;

    logic [5:0]      shamt;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic [31:0]     srlw_res;
    logic [31:0]     sraw_res;
    logic [XLEN-1:0] raw;                       // before word sign-extension

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];  // 5 bits in word mode

    // shifts kept apart so the signed ones stay arithmetic
    assign sll_res  = a << shamt;               // low half is the sllw result
    assign srl_res  = a >> shamt;
    assign sra_res  = $signed(a) >>> shamt;
    assign srlw_res = a[31:0] >> shamt[4:0];    // word shifts see only a[31:0]
    assign sraw_res = $signed(a[31:0]) >>> shamt[4:0];  // fills from bit 31

    always_comb begin
        case (op)
            ALU_ADD:   raw = a + b;
            ALU_SUB:   raw = a - b;
            ALU_SLL:   raw = sll_res;
            ALU_SLT:   raw = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:  raw = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:   raw = a ^ b;
            ALU_SRL: begin
                if (word) begin
                    raw = {32'b0, srlw_res};    // upper half replaced below
                end else begin
                    raw = srl_res;
                end
            end
            ALU_SRA: begin
                if (word) begin
                    raw = {32'b0, sraw_res};
                end else begin
                    raw = sra_res;
                end
            end
            ALU_OR:    raw = a | b;
            ALU_AND:   raw = a & b;
            ALU_LUI:   raw = b;                 // imm already shifted by decode
            ALU_AUIPC: raw = pc + b;
            default:   raw = '0;
        endcase
    end

    // word ops return sign-extended low 32 bits
    assign result = word ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

//--- rv_stage_reg.sv
// Valid/ready pipeline register
`default_nettype none

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_data,
    output logic     down_valid,
    input  logic     down_ready,
    output payload_t down_data
);

    logic load;                                 // upstream transfer this cycle

    // free when empty or when the held item leaves this cycle
    assign up_ready = !down_valid || down_ready;
    assign load     = up_valid && up_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            down_valid <= 1'b0;
        end else if (up_ready) begin
            down_valid <= up_valid;             // refill or drain
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (load) begin
            down_data <= up_data;
        end
    end

endmodule

`default_nettype wire

//--- rv_int_core.sv
// RV64 integer execute path
`default_nettype none

module rv_int_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  rv_core_pkg::inst_in_t in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output rv_core_pkg::wb_t      out_data
);
    import rv_core_pkg::*;

    decoded_t        dec;
    exec_t           ex_in;                     // into stage 1
    exec_t           ex_q;                      // held in stage 1
    wb_t             wb_in;                     // into stage 2
    logic            ex_valid;
    logic            ex_ready;
    logic            retire_we;
    logic [XLEN-1:0] rf_rs1;
    logic [XLEN-1:0] rf_rs2;
    logic [XLEN-1:0] alu_result;

    // youngest producer wins, x0 never forwarded
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rf_val);
        logic [XLEN-1:0] val;
        val = rf_val;
        if (addr != '0) begin
            if (ex_valid && ex_q.dec.writes_rd && (ex_q.dec.rd == addr)) begin
                val = alu_result;               // stage 1, still in the ALU
            end else if (out_valid && out_data.writes_rd && (out_data.rd == addr)) begin
                val = out_data.value;           // stage 2, not yet retired
            end
        end
        return val;
    endfunction

    rv_idu idu_inst (
        .inst (in_data.inst),
        .pc   (in_data.pc),
        .dec  (dec)
    );

    // written at retirement only, so state stays in order
    assign retire_we = out_valid && out_ready && out_data.writes_rd;

    rv_regfile regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .we       (retire_we),
        .wr_addr  (out_data.rd),
        .wr_data  (out_data.value)
    );

    always_comb begin
        ex_in.dec  = dec;
        ex_in.op_a = resolve(dec.rs1, rf_rs1);
        ex_in.op_b = dec.use_imm ? dec.imm : resolve(dec.rs2, rf_rs2);  // imm takes port b
    end

    rv_stage_reg #(.payload_t(exec_t)) ex_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .up_valid   (in_valid),
        .up_ready   (in_ready),
        .up_data    (ex_in),
        .down_valid (ex_valid),
        .down_ready (ex_ready),
        .down_data  (ex_q)
    );

    rv_alu alu_inst (
        .op     (ex_q.dec.alu_op),
        .word   (ex_q.dec.word),
        .a      (ex_q.op_a),
        .b      (ex_q.op_b),
        .pc     (ex_q.dec.pc),
        .result (alu_result)
    );

    // writeback record
    always_comb begin
        wb_in.pc        = ex_q.dec.pc;
        wb_in.rd        = ex_q.dec.rd;
        wb_in.value     = alu_result;           // don't care for illegal/ebreak
        wb_in.writes_rd = ex_q.dec.writes_rd;
        wb_in.illegal   = ex_q.dec.illegal;
        wb_in.ebreak    = ex_q.dec.ebreak;
    end

    rv_stage_reg #(.payload_t(wb_t)) wb_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .up_valid   (ex_valid),
        .up_ready   (ex_ready),
        .up_data    (wb_in),
        .down_valid (out_valid),
        .down_ready (out_ready),
        .down_data  (out_data)
    );

endmodule

`default_nettype wire

//--- tb_rv_int_core.sv
// Integer core random testbench
`default_nettype none

module tb_rv_int_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_core_pkg::*;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    inst_in_t    in_data;
    logic        out_valid;
    logic        out_ready;
    wb_t         out_data;

    logic [63:0] regs_model [0:31];             // architectural state of the model
    wb_t         exp_q [$];                     // expected records in program order
    int          acc_cyc_q [$];                 // acceptance cycle per record
    int          seed;
    int          cycle;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    bit          rand_ready;                    // random back-pressure on
    bit          check_lat;                     // 2-cycle latency check on
    logic [4:0]  last_rd [0:1];
    logic [63:0] next_pc;

    rv_int_core rv_int_core_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // ISA reference for the supported subset
    function automatic void exec_ref(input logic [31:0] inst, input logic [63:0] pc,
                                     input logic [63:0] a, input logic [63:0] b,
                                     output logic legal, output logic [63:0] val);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] imm;
        logic [5:0]  sh6;
        logic [4:0]  sh5;
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm   = {{52{inst[31]}}, inst[31:20]};
        sh6   = inst[25:20];
        sh5   = inst[24:20];
        legal = 1'b1;
        val   = '0;
        case (inst[6:0])
            7'h33: begin                        // OP
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                case (f3)
                    3'd0: val = f7[5] ? a - b : a + b;
                    3'd1: val = a << b[5:0];
                    3'd2: val = {63'b0, $signed(a) < $signed(b)};
                    3'd3: val = {63'b0, a < b};
                    3'd4: val = a ^ b;
                    3'd5: val = f7[5] ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
                    3'd6: val = a | b;
                    default: val = a & b;
                endcase
            end
            7'h13: begin                        // OP-IMM
                if (f3 == 3'd1 && inst[31:26] != 6'h00) legal = 1'b0;
                if (f3 == 3'd5 && inst[31:26] != 6'h00 && inst[31:26] != 6'h10) legal = 1'b0;
                case (f3)
                    3'd0: val = a + imm;
                    3'd1: val = a << sh6;
                    3'd2: val = {63'b0, $signed(a) < $signed(imm)};
                    3'd3: val = {63'b0, a < imm};
                    3'd4: val = a ^ imm;
                    3'd5: val = inst[30] ? 64'($signed(a) >>> sh6) : a >> sh6;
                    3'd6: val = a | imm;
                    default: val = a & imm;
                endcase
            end
            7'h3b: begin                        // OP-32
                legal = (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
                        (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                if (f3 == 3'd0) val = sext32(f7[5] ? a[31:0] - b[31:0] : a[31:0] + b[31:0]);
                if (f3 == 3'd1) val = sext32(a[31:0] << b[4:0]);
                if (f3 == 3'd5) val = f7[5] ? sext32(32'($signed(a[31:0]) >>> b[4:0]))
                                            : sext32(a[31:0] >> b[4:0]);
            end
            7'h1b: begin                        // OP-IMM-32
                legal = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                        (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
                if (f3 == 3'd0) val = sext32(a[31:0] + imm[31:0]);
                if (f3 == 3'd1) val = sext32(a[31:0] << sh5);
                if (f3 == 3'd5) val = f7[5] ? sext32(32'($signed(a[31:0]) >>> sh5))
                                            : sext32(a[31:0] >> sh5);
            end
            7'h37:   val = sext32({inst[31:12], 12'b0});         // lui
            7'h17:   val = pc + sext32({inst[31:12], 12'b0});    // auipc
            default: legal = 1'b0;
        endcase
    endfunction

    // applied at acceptance in program order
    function automatic void model_accept(input inst_in_t it);
        logic        legal;
        logic [63:0] val;
        wb_t         e;
        exec_ref(it.inst, it.pc, regs_model[it.inst[19:15]], regs_model[it.inst[24:20]],
                 legal, val);
        e.ebreak    = (it.inst == 32'h0010_0073);
        e.pc        = it.pc;
        e.rd        = it.inst[11:7];
        e.value     = val;
        e.writes_rd = legal && !e.ebreak && (e.rd != 5'd0);
        e.illegal   = !legal && !e.ebreak;
        if (e.writes_rd) regs_model[e.rd] = val;
        exp_q.push_back(e);
        acc_cyc_q.push_back(cycle);
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // output compare and model update on each rising edge
    always @(posedge clk) begin : monitor
        wb_t e;
        int  acc;
        cycle++;
        if (!reset) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output record at pc %h with nothing expected", out_data.pc);
                    errors++;
                end else begin
                    e   = exp_q.pop_front();
                    acc = acc_cyc_q.pop_front();
                    check("pc", out_data.pc, e.pc);
                    check("rd", 64'(out_data.rd), 64'(e.rd));
                    check("writes_rd", 64'(out_data.writes_rd), 64'(e.writes_rd));
                    check("illegal", 64'(out_data.illegal), 64'(e.illegal));
                    check("ebreak", 64'(out_data.ebreak), 64'(e.ebreak));
                    if (e.writes_rd) check("value", out_data.value, e.value);
                    if (check_lat && (cycle - acc != 2)) begin
                        $display("result at pc %h came %0d cycles after acceptance",
                                 e.pc, cycle - acc);
                        errors++;
                    end
                end
            end
            if (in_valid && in_ready) model_accept(in_data);
        end
    end

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        @(negedge clk);
        r = $random(seed);
        out_ready = rand_ready ? r[0] : 1'b1;
    endtask

    task automatic send(input logic [31:0] inst);
        int n;
        bit acc;
        in_data.pc   = next_pc;
        in_data.inst = inst;
        in_valid     = 1'b1;
        next_pc      = next_pc + 64'd4;
        n   = 0;
        acc = 1'b0;
        while (!acc && n < 200) begin
            @(posedge clk);
            acc = in_ready;                     // sampled before the edge updates
            if (!rand_ready) check("in_ready", 64'(in_ready), 64'd1);  // full rate
            next_cycle_tail();
            n++;
        end
        if (!acc) begin
            $display("instruction at pc %h was never accepted", in_data.pc);
            errors++;
        end
    endtask

    task automatic next_cycle_tail();
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        out_ready = rand_ready ? r[0] : 1'b1;
    endtask

    task automatic drain();
        int n;
        in_valid = 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 1000) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d results still outstanding after timeout", exp_q.size());
            errors++;
            exp_q.delete();
            acc_cyc_q.delete();
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // biased toward recent destinations
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        logic [31:0] s;
        r = $random(seed);
        s = $random(seed);
        if (r[2:0] < 3'd3) return last_rd[0];
        if (r[2:0] < 3'd5) return last_rd[1];
        return s[4:0];
    endfunction

    function automatic logic [31:0] with_rd(input logic [31:0] inst);
        last_rd[1] = last_rd[0];
        last_rd[0] = inst[11:7];
        return inst;
    endfunction

    function automatic logic [31:0] gen_rr(input bit word);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        r   = $random(seed);
        f3  = word ? ((r[4:3] == 2'd0) ? 3'd0 : (r[4:3] == 2'd1) ? 3'd1 : 3'd5) : r[2:0];
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[5]) ? 7'h20 : 7'h00;
        rs1 = pick_reg();
        rs2 = pick_reg();
        rd  = pick_reg();
        return with_rd({f7, rs2, rs1, f3, rd, word ? 7'h3b : 7'h33});
    endfunction

    function automatic logic [31:0] gen_imm();
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        r   = $random(seed);
        imm = $random(seed);
        rs1 = pick_reg();
        rd  = pick_reg();
        f3  = r[0] ? 3'd1 : 3'd5;
        case (r[10:8] % 3'd6)
            3'd0: begin                         // non-shift op with sign-extended imm
                f3 = r[6:4];
                if (f3 == 3'd1 || f3 == 3'd5) f3 = 3'd0;
                return with_rd({imm[11:0], rs1, f3, rd, 7'h13});
            end
            3'd1: return with_rd({(f3 == 3'd5 && r[1]) ? 6'h10 : 6'h00, imm[5:0],
                                  rs1, f3, rd, 7'h13});
            3'd2: return with_rd({imm[11:0], rs1, 3'd0, rd, 7'h1b});
            3'd3: return with_rd({(f3 == 3'd5 && r[1]) ? 7'h20 : 7'h00, imm[4:0],
                                  rs1, f3, rd, 7'h1b});
            3'd4: return with_rd({imm[19:0], rd, 7'h37});
            default: return with_rd({imm[19:0], rd, 7'h17});
        endcase
    endfunction

    function automatic logic [31:0] gen_mix();
        logic [31:0] r;
        r = $random(seed);
        return r[0] ? gen_rr(r[1]) : gen_imm();
    endfunction

    initial begin
        int          base;
        logic [31:0] inst;
        logic [4:0]  prev;
        logic [4:0]  prev2;
        logic        legal;
        logic [63:0] val;
        seed = 32'h63d12cbe;
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b1;
        rand_ready = 1'b0;
        check_lat = 1'b0;
        next_pc = 64'h1000;
        cycle = 0;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        last_rd[0] = 5'd1;
        last_rd[1] = 5'd2;
        for (int i = 0; i < 32; i++) regs_model[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        base = errors;
        check("out_valid", 64'(out_valid), 64'd0);        // pipeline empty after reset
        check("in_ready", 64'(in_ready), 64'd1);
        check_lat = 1'b1;
        for (int i = 0; i < 200; i++) send(gen_rr(i[0]));
        drain();
        report("register-register", base);

        base = errors;
        for (int i = 0; i < 200; i++) send(gen_imm());
        drain();
        report("immediate", base);

        base = errors;                          // dependent chains issued back to back
        prev = 5'd3;
        prev2 = 5'd4;
        for (int i = 0; i < 150; i++) begin
            inst = gen_mix();
            inst[19:15] = prev;
            if (inst[6:0] == 7'h33 || inst[6:0] == 7'h3b) inst[24:20] = prev2;
            if (inst[11:7] == 5'd0) inst[11:7] = 5'd1;
            prev2 = prev;
            prev = inst[11:7];
            send(inst);
        end
        drain();
        report("forwarding chains", base);

        base = errors;
        check_lat = 1'b0;
        rand_ready = 1'b1;
        for (int i = 0; i < 300; i++) send(gen_mix());
        drain();
        rand_ready = 1'b0;
        report("back-pressure mix", base);

        base = errors;
        for (int i = 0; i < 40; i++) begin
            do begin
                inst = $random(seed);
                exec_ref(inst, 64'd0, 64'd0, 64'd0, legal, val);
            end while (legal || inst == 32'h0010_0073);
            send(inst);
            if (i % 4 == 0) send(32'h0010_0073);
            send({7'h00, 5'd0, inst[11:7], 3'd0, 5'd31, 7'h33});  // x31 = old rd
        end
        drain();
        report("illegal and ebreak", base);

        base = errors;
        for (int i = 0; i < 30; i++) begin
            inst = gen_mix();
            inst[11:7] = 5'd0;
            send(inst);
            send({7'h00, 5'd0, 5'd0, 3'd0, 5'd9, 7'h33});       // x9 = x0 + x0
        end
        drain();
        report("x0 writes", base);

        $display("%0d tests passed, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rv_core_pkg.sv
rv_idu.sv
rv_regfile.sv
rv_alu.sv
rv_stage_reg.sv
rv_int_core.sv
tb_rv_int_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the integer core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_rv_int_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_int_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
